// File: dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  // ----------------------------------------------------------
  // Debug bus address as one word seen two ways
  // ----------------------------------------------------------
  typedef union packed {
    struct packed {
      logic [17:0] pad_hi;
      logic [5:0]  region;   // Register window select
      logic        pad_mid;
      logic [4:0]  idx;      // Register within the window
      logic [1:0]  pad_lo;   // Byte offset within the word
    } win;
    struct packed {
      logic [24:0] pad_hi;
      logic [4:0]  num;      // GPR number x0..x31
      logic [1:0]  pad_lo;
    } gpr;
  } dbg_addr_u;

  // Region codes in address bits 13..8
  localparam logic [5:0] REGION_DBG_ALWAYS = 6'h00;
  localparam logic [5:0] REGION_DBG_HALTED = 6'h20;
  localparam logic [5:0] REGION_GPR        = 6'h04;

  // Always-accessible window
  localparam logic [4:0] REG_CTRL  = 5'd0;
  localparam logic [4:0] REG_HIT   = 5'd1;
  localparam logic [4:0] REG_IE    = 5'd2;
  localparam logic [4:0] REG_CAUSE = 5'd3;

  // Halted-only window picked by index bit 0
  localparam logic REG_NPC = 1'b0;
  localparam logic REG_PPC = 1'b1;

  // Settings vector toward the core
  localparam int DBG_SETS_W = 5;
  localparam int SETS_SSTE  = 0;   // Single-step enable
  localparam int SETS_ECALL = 1;
  localparam int SETS_ELSU  = 2;   // Load/store fault from either IE bit
  localparam int SETS_EBRK  = 3;
  localparam int SETS_EILL  = 4;

  localparam int         CTRL_HALT_BIT = 16;
  localparam logic [5:0] CAUSE_HALT    = 6'h1F;   // Halt by request rather than a trap

  // Pending read source
  typedef enum logic [2:0] {
    RD_NONE,
    RD_GPR,
    RD_WIN,
    RD_PC
  } rd_sel_e;

endpackage

`default_nettype wire

// File: dbg_access_decoder.sv
`default_nettype none

module dbg_access_decoder import dbg_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Debug bus request side
  input  logic                      debug_req_i,
  input  logic                      debug_we_i,
  input  dbg_addr_u                 debug_addr_i,
  input  logic [31:0]               debug_wdata_i,
  output logic                      debug_gnt_o,

  input  logic                      halted_i,    // Core parked in debug

  // Toward the halt controller
  output logic                      halt_wr_o,
  output logic                      resume_wr_o,
  output logic                      hit_clr_o,

  output rd_sel_e                   rd_sel_o,    // Read source in the request cycle
  output logic [DBG_SETS_W-1:0]     settings_o,

  // Register file ports
  output logic                      regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_raddr_o,
  output logic                      regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_o,
  output logic [31:0]               regfile_wdata_o,

  // PC redirect
  output logic                      jump_req_o,
  output logic [31:0]               jump_addr_o
);

  logic [DBG_SETS_W-1:0]     settings_q, settings_n;
  logic                      regfile_rreq_q, regfile_rreq_n;
  logic                      jump_req_q, jump_req_n;
  logic [REG_ADDR_WIDTH-1:0] raddr_q;      // GPR index of the last read
  logic [31:0]               jump_addr_q;
  logic                      wr_req;
  logic                      rd_req;

  assign debug_gnt_o = debug_req_i;       // Never blocks, even on bad accesses
  assign wr_req      = debug_req_i &  debug_we_i;
  assign rd_req      = debug_req_i & ~debug_we_i;

  // ----------------------------------------------------------
  // Request decode
  // ----------------------------------------------------------
  always_comb begin
    halt_wr_o      = 1'b0;
    resume_wr_o    = 1'b0;
    hit_clr_o      = 1'b0;
    settings_n     = settings_q;
    jump_req_n     = 1'b0;
    regfile_wreq_o = 1'b0;
    regfile_rreq_n = 1'b0;
    rd_sel_o       = RD_NONE;

    if (wr_req) begin
      case (debug_addr_i.win.region)
        REGION_DBG_ALWAYS: begin
          case (debug_addr_i.win.idx)
            REG_CTRL: begin
              halt_wr_o             =  debug_wdata_i[CTRL_HALT_BIT];
              resume_wr_o           = ~debug_wdata_i[CTRL_HALT_BIT];
              settings_n[SETS_SSTE] =  debug_wdata_i[0];
            end
            REG_HIT: hit_clr_o = debug_wdata_i[0];   // Write 1 to clear
            REG_IE: begin
              settings_n[SETS_ECALL] = debug_wdata_i[11];
              settings_n[SETS_ELSU]  = debug_wdata_i[7] | debug_wdata_i[5];
              settings_n[SETS_EBRK]  = debug_wdata_i[3];
              settings_n[SETS_EILL]  = debug_wdata_i[2];
            end
            default: ;   // CAUSE is read only
          endcase
        end
        REGION_DBG_HALTED: begin
          // DNPC write redirects the core
          if (halted_i && debug_addr_i.win.idx == {4'b0, REG_NPC}) begin
            jump_req_n = 1'b1;
          end
        end
        REGION_GPR: regfile_wreq_o = halted_i;
        default: ;
      endcase
    end else if (rd_req) begin
      case (debug_addr_i.win.region)
        REGION_DBG_ALWAYS: rd_sel_o = RD_WIN;
        REGION_DBG_HALTED: begin
          if (halted_i && debug_addr_i.win.idx[4:1] == 4'b0) begin
            rd_sel_o = RD_PC;   // NPC or PPC
          end
        end
        REGION_GPR: begin
          if (halted_i) begin
            regfile_rreq_n = 1'b1;
            rd_sel_o       = RD_GPR;
          end
        end
        default: ;   // Unmapped region reads zero
      endcase
    end
  end

  // ----------------------------------------------------------
  // Registered requests and settings
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q     <= '0;
      regfile_rreq_q <= 1'b0;
      jump_req_q     <= 1'b0;
    end else begin
      settings_q     <= settings_n;
      regfile_rreq_q <= regfile_rreq_n;   // One-cycle pulse
      jump_req_q     <= jump_req_n;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      raddr_q <= debug_addr_i.gpr.num[REG_ADDR_WIDTH-1:0];
    end
    if (jump_req_n) begin
      jump_addr_q <= debug_wdata_i;   // Target of the DNPC write
    end
  end

  assign settings_o      = settings_q;
  assign regfile_rreq_o  = regfile_rreq_q;
  assign regfile_raddr_o = raddr_q;
  assign regfile_waddr_o = debug_addr_i.gpr.num[REG_ADDR_WIDTH-1:0];
  assign regfile_wdata_o = debug_wdata_i;
  assign jump_req_o      = jump_req_q;
  assign jump_addr_o     = jump_addr_q;

endmodule

`default_nettype wire

// File: dbg_halt_ctrl.sv
`default_nettype none

module dbg_halt_ctrl import dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Register writes from the decoder
  input  logic       halt_wr_i,
  input  logic       resume_wr_i,
  input  logic       hit_clr_i,

  // External halt pins
  input  logic       debug_halt_i,
  input  logic       debug_resume_i,

  // Core exception side
  input  logic       trap_i,
  input  logic [5:0] exc_cause_i,
  input  logic       sste_i,        // Single-step enable setting

  // Core handshake
  output logic       dbg_req_o,
  input  logic       dbg_ack_i,
  output logic       stall_o,

  output logic       halted_o,
  output logic [5:0] cause_o,
  output logic       ssth_o        // Single-step hit
);

  localparam logic [1:0] ST_RUN  = 2'd0;
  localparam logic [1:0] ST_HREQ = 2'd1;   // Waiting for core ack
  localparam logic [1:0] ST_HALT = 2'd2;

  logic [1:0] state_q, state_n;
  logic [5:0] cause_q, cause_n;
  logic       ssth_q, ssth_n;
  logic       resume;

  assign resume = resume_wr_i | debug_resume_i;

  // ----------------------------------------------------------
  // Run / halt-request / halt FSM
  // ----------------------------------------------------------
  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    ssth_n    = ssth_q;
    dbg_req_o = 1'b0;
    stall_o   = 1'b0;

    case (state_q)
      ST_RUN: begin
        ssth_n = 1'b0;   // Hit flag only lives while stopped
        if (halt_wr_i || debug_halt_i || trap_i) begin
          dbg_req_o = 1'b1;   // Same-cycle request to the core
          state_n   = ST_HREQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = sste_i;
          end else begin
            cause_n = CAUSE_HALT;
          end
        end
      end
      ST_HREQ: begin
        dbg_req_o = 1'b1;   // Held until ack
        if (dbg_ack_i) begin
          state_n = ST_HALT;
        end
        if (resume) begin
          state_n = ST_RUN;   // Resume wins over a late ack
        end
      end
      ST_HALT: begin
        // halt_wr_i has no effect here
        stall_o = 1'b1;
        if (resume) begin
          state_n = ST_RUN;
          stall_o = 1'b0;   // Release the core right away
        end
      end
      default: state_n = ST_RUN;
    endcase

    if (hit_clr_i) begin
      ssth_n = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
      cause_q <= CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign halted_o = (state_q == ST_HALT);
  assign cause_o  = cause_q;
  assign ssth_o   = ssth_q;

endmodule

`default_nettype wire

// File: dbg_read_resp.sv
`default_nettype none

module dbg_read_resp import dbg_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  debug_gnt_i,
  input  dbg_addr_u             debug_addr_i,
  input  rd_sel_e               rd_sel_i,

  // State to report
  input  logic                  halted_i,
  input  logic                  ssth_i,
  input  logic                  sleeping_i,
  input  logic [5:0]            cause_i,
  input  logic [DBG_SETS_W-1:0] settings_i,
  input  logic [31:0]           regfile_rdata_i,
  input  logic [31:0]           pc_if_i,
  input  logic [31:0]           pc_id_i,

  output logic                  debug_rvalid_o,
  output logic [31:0]           debug_rdata_o
);

  rd_sel_e     rd_sel_q;
  logic [4:0]  idx_q;       // Register index of the granted access
  logic [31:0] win_word;

  // ----------------------------------------------------------
  // Grant-edge capture
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      rd_sel_q       <= RD_NONE;
    end else begin
      debug_rvalid_o <= debug_gnt_i;   // Always one cycle behind grant
      if (debug_gnt_i) begin
        rd_sel_q <= rd_sel_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (debug_gnt_i) begin
      idx_q <= debug_addr_i.win.idx;
    end
  end

  // Always-accessible window
  always_comb begin
    win_word = '0;
    case (idx_q)
      REG_CTRL: begin
        win_word[CTRL_HALT_BIT] = halted_i;
        win_word[0]             = settings_i[SETS_SSTE];
      end
      REG_HIT: begin
        win_word[16] = sleeping_i;
        win_word[0]  = ssth_i;
      end
      REG_IE: begin
        win_word[11] = settings_i[SETS_ECALL];
        win_word[7]  = settings_i[SETS_ELSU];   // ELSU shows in both
        win_word[5]  = settings_i[SETS_ELSU];
        win_word[3]  = settings_i[SETS_EBRK];
        win_word[2]  = settings_i[SETS_EILL];
      end
      REG_CAUSE: begin
        win_word[31]  = cause_i[5];       // Interrupt flag
        win_word[4:0] = cause_i[4:0];
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Read data mux
  // ----------------------------------------------------------
  always_comb begin
    case (rd_sel_q)
      RD_GPR:  debug_rdata_o = regfile_rdata_i;
      RD_WIN:  debug_rdata_o = win_word;
      RD_PC:   debug_rdata_o = (idx_q[0] == REG_NPC) ? pc_if_i : pc_id_i;
      default: debug_rdata_o = '0;   // Denied or unmapped
    endcase
  end

endmodule

`default_nettype wire

// File: debug_unit.sv
`default_nettype none

module debug_unit import dbg_pkg::*; #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Debug bus
  input  logic                      debug_req_i,
  output logic                      debug_gnt_o,
  output logic                      debug_rvalid_o,
  input  dbg_addr_u                 debug_addr_i,
  input  logic                      debug_we_i,
  input  logic [31:0]               debug_wdata_i,
  output logic [31:0]               debug_rdata_o,

  // Halt pins
  output logic                      debug_halted_o,
  input  logic                      debug_halt_i,
  input  logic                      debug_resume_i,

  // Core control
  output logic [DBG_SETS_W-1:0]     settings_o,
  input  logic                      trap_i,
  input  logic [5:0]                exc_cause_i,
  output logic                      stall_o,
  output logic                      dbg_req_o,
  input  logic                      dbg_ack_i,
  input  logic                      sleeping_i,

  // Register file
  output logic                      regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_raddr_o,
  input  logic [31:0]               regfile_rdata_i,
  output logic                      regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_o,
  output logic [31:0]               regfile_wdata_o,

  // PC view and redirect
  input  logic [31:0]               pc_if_i,
  input  logic [31:0]               pc_id_i,
  output logic                      jump_req_o,
  output logic [31:0]               jump_addr_o
);

  logic       halt_wr;
  logic       resume_wr;
  logic       hit_clr;
  logic       halted;
  logic       ssth;
  logic [5:0] cause;
  rd_sel_e    rd_sel;

  // ----------------------------------------------------------
  // Bus decode, halt FSM and read response
  // ----------------------------------------------------------
  dbg_access_decoder #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_we_i      (debug_we_i),
    .debug_addr_i    (debug_addr_i),
    .debug_wdata_i   (debug_wdata_i),
    .debug_gnt_o     (debug_gnt_o),
    .halted_i        (halted),
    .halt_wr_o       (halt_wr),
    .resume_wr_o     (resume_wr),
    .hit_clr_o       (hit_clr),
    .rd_sel_o        (rd_sel),
    .settings_o      (settings_o),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o)
  );

  dbg_halt_ctrl u_halt_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .halt_wr_i      (halt_wr),
    .resume_wr_i    (resume_wr),
    .hit_clr_i      (hit_clr),
    .debug_halt_i   (debug_halt_i),
    .debug_resume_i (debug_resume_i),
    .trap_i         (trap_i),
    .exc_cause_i    (exc_cause_i),
    .sste_i         (settings_o[SETS_SSTE]),
    .dbg_req_o      (dbg_req_o),
    .dbg_ack_i      (dbg_ack_i),
    .stall_o        (stall_o),
    .halted_o       (halted),
    .cause_o        (cause),
    .ssth_o         (ssth)
  );

  dbg_read_resp u_read_resp (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_gnt_i     (debug_gnt_o),
    .debug_addr_i    (debug_addr_i),
    .rd_sel_i        (rd_sel),
    .halted_i        (halted),
    .ssth_i          (ssth),
    .sleeping_i      (sleeping_i),
    .cause_i         (cause),
    .settings_i      (settings_o),
    .regfile_rdata_i (regfile_rdata_i),
    .pc_if_i         (pc_if_i),
    .pc_id_i         (pc_id_i),
    .debug_rvalid_o  (debug_rvalid_o),
    .debug_rdata_o   (debug_rdata_o)
  );

  assign debug_halted_o = halted;

endmodule

`default_nettype wire

// File: debug_unit_asserts.sv
`default_nettype none

module debug_unit_asserts import dbg_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        debug_req_i,
  input logic        debug_we_i,
  input logic [31:0] debug_addr_i,
  input logic [31:0] debug_wdata_i,
  input logic        debug_gnt_o,
  input logic        debug_rvalid_o,
  input logic [31:0] debug_rdata_o,
  input logic        debug_halted_o,
  input logic        stall_o,
  input logic        dbg_req_o,
  input logic        dbg_ack_i,
  input logic        regfile_wreq_o,
  input logic        regfile_rreq_o,
  input logic        jump_req_o,
  input logic [31:0] jump_addr_o,
  input logic [31:0] pc_if_i,
  input logic [31:0] pc_id_i
);

  int   fail_cnt = 0;
  logic rd_req, wr_req;
  logic in_halted_win, in_gpr;

  assign rd_req        = debug_req_i & ~debug_we_i;
  assign wr_req        = debug_req_i &  debug_we_i;
  assign in_halted_win = (debug_addr_i[13:8] == REGION_DBG_HALTED);
  assign in_gpr        = (debug_addr_i[13:8] == REGION_GPR);

  // ------------------------------------------------------------
  // Bus handshake
  // ------------------------------------------------------------
  a_gnt: assert property (@(posedge clk) debug_gnt_o == debug_req_i)
    else begin
      $error("grant differs from request");
      fail_cnt++;
    end
  a_rvalid: assert property (@(posedge clk) disable iff (!rst_n) debug_gnt_o |=> debug_rvalid_o)
    else begin
      $error("no read-valid after grant");
      fail_cnt++;
    end
  a_no_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
                                !debug_gnt_o |=> !debug_rvalid_o)
    else begin
      $error("read-valid without grant");
      fail_cnt++;
    end

  // Quiet outputs while in reset
  a_reset: assert property (@(posedge clk) !rst_n |-> !debug_rvalid_o && !debug_halted_o &&
                            !stall_o && !dbg_req_o && !regfile_rreq_o && !regfile_wreq_o &&
                            !jump_req_o)
    else begin
      $error("control output high in reset");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // Halt handshake
  // ------------------------------------------------------------
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                               dbg_req_o && !dbg_ack_i |=> dbg_req_o)
    else begin
      $error("halt request dropped before ack");
      fail_cnt++;
    end
  a_halt_ack: assert property (@(posedge clk) disable iff (!rst_n)
                               dbg_req_o && dbg_ack_i |=> debug_halted_o && stall_o)
    else begin
      $error("no halt after ack");
      fail_cnt++;
    end
  a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall_o |-> debug_halted_o)
    else begin
      $error("stall while not halted");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // Halted-only access
  // ------------------------------------------------------------
  a_no_wr_run: assert property (@(posedge clk) !debug_halted_o |-> !regfile_wreq_o)
    else begin
      $error("regfile write while running");
      fail_cnt++;
    end
  a_gpr_run: assert property (@(posedge clk) disable iff (!rst_n)
                              rd_req && in_gpr && !debug_halted_o |=> debug_rdata_o == 32'h0)
    else begin
      $error("GPR read while running not zero");
      fail_cnt++;
    end
  a_rreq: assert property (@(posedge clk) disable iff (!rst_n)
                           rd_req && in_gpr && debug_halted_o |=> regfile_rreq_o)
    else begin
      $error("no regfile read request");
      fail_cnt++;
    end
  a_npc: assert property (@(posedge clk) disable iff (!rst_n)
                          rd_req && in_halted_win && debug_addr_i[6:2] == 5'd0 &&
                          debug_halted_o |=> debug_rdata_o == pc_if_i)
    else begin
      $error("NPC read mismatch");
      fail_cnt++;
    end
  a_ppc: assert property (@(posedge clk) disable iff (!rst_n)
                          rd_req && in_halted_win && debug_addr_i[6:2] == 5'd1 &&
                          debug_halted_o |=> debug_rdata_o == pc_id_i)
    else begin
      $error("PPC read mismatch");
      fail_cnt++;
    end
  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
                           wr_req && in_halted_win && debug_addr_i[6:2] == 5'd0 &&
                           debug_halted_o |=> jump_req_o && jump_addr_o == $past(debug_wdata_i))
    else begin
      $error("DNPC write did not redirect");
      fail_cnt++;
    end

endmodule

bind debug_unit debug_unit_asserts u_asserts (.*);

`default_nettype wire

// File: tb_debug_unit.sv
`default_nettype none

module tb_debug_unit import dbg_pkg::*;;

  localparam int REG_ADDR_WIDTH = 5;
  localparam int NUM_TESTS      = 6;
  localparam int CLK_PERIOD     = 8;

  logic                      clk;
  logic                      rst_n;
  logic                      debug_req_i, debug_we_i;
  dbg_addr_u                 debug_addr_i;
  logic [31:0]               debug_wdata_i;
  logic                      debug_gnt_o, debug_rvalid_o;
  logic [31:0]               debug_rdata_o;
  logic                      debug_halted_o, debug_halt_i, debug_resume_i;
  logic [DBG_SETS_W-1:0]     settings_o;
  logic                      trap_i;
  logic [5:0]                exc_cause_i;
  logic                      stall_o, dbg_req_o, dbg_ack_i, sleeping_i;
  logic                      regfile_rreq_o, regfile_wreq_o;
  logic [REG_ADDR_WIDTH-1:0] regfile_raddr_o, regfile_waddr_o;
  logic [31:0]               regfile_rdata_i, regfile_wdata_o;
  logic [31:0]               pc_if_i, pc_id_i;
  logic                      jump_req_o;
  logic [31:0]               jump_addr_o;

  logic [31:0] lfsr = 32'hae888b42;
  logic [31:0] gpr_mem [32];        // Core register file model
  logic        req_seen;
  logic [31:0] last_jump;
  int          jump_cnt  = 0;
  int          errors    = 0;
  int          tests_ok  = 0;
  int          tests_bad = 0;

  debug_unit #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Core model
  // ------------------------------------------------------------
  always @(negedge clk) req_seen = dbg_req_o;
  always @(posedge clk) begin
    #1 dbg_ack_i = req_seen & rst_n;   // Ack one cycle after request
  end
  assign regfile_rdata_i = gpr_mem[regfile_raddr_o];
  always @(negedge clk) begin
    if (regfile_wreq_o) gpr_mem[regfile_waddr_o] <= regfile_wdata_o;
  end
  always @(negedge clk) begin
    if (jump_req_o) begin
      last_jump = jump_addr_o;
      jump_cnt++;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] next_random(input int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < nbits; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic dbg_addr_u win_addr(input logic [5:0] region, input logic [4:0] idx);
    dbg_addr_u a;
    a            = '0;
    a.win.region = region;
    a.win.idx    = idx;
    return a;
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_asserts.fail_cnt;
  endfunction

  // ------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------
  task automatic bus_access(input logic we, input dbg_addr_u addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    n             = 0;
    debug_req_i   = 1'b1;
    debug_we_i    = we;
    debug_addr_i  = addr;
    debug_wdata_i = wdata;
    @(negedge clk);
    while (!debug_gnt_o && n < 16) begin
      n++;
      @(negedge clk);
    end
    if (!debug_gnt_o) begin
      $display("Request to address %h at %0t was never granted", addr, $time);
      errors++;
    end
    @(posedge clk);
    #1;
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!debug_rvalid_o && n < 16) begin   // Wait for read-valid
      n++;
      @(negedge clk);
    end
    if (!debug_rvalid_o) begin
      $display("No read-valid after request at %0t", $time);
      errors++;
    end
    rdata = debug_rdata_o;
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input dbg_addr_u addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_read(input string name, input dbg_addr_u addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, addr, 32'h0, rd);
    check_val(name, exp, rd);
  endtask

  task automatic wait_halted(input logic want);
    int n;
    n = 0;
    @(negedge clk);
    while (debug_halted_o !== want && n < 20) begin
      n++;
      @(negedge clk);
    end
    if (debug_halted_o !== want) begin
      $display("Halted state did not become %0b by %0t", want, $time);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (total_errors() == errs_before) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: FAILED", name);
      tests_bad++;
    end
  endtask

  // Watchdog stops the run after 200 cycles per test
  initial begin
    #(CLK_PERIOD * 200 * NUM_TESTS);
    $display("Watchdog expired at %0t, run stopped", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  initial begin
    logic [31:0] data, ie, exp;
    logic [4:0]  num;
    logic [5:0]  cause;
    int          e0, jumps;
    clk            = 1'b0;
    rst_n          = 1'b0;
    debug_req_i    = 1'b0;
    debug_we_i     = 1'b0;
    debug_addr_i   = '0;
    debug_wdata_i  = '0;
    debug_halt_i   = 1'b0;
    debug_resume_i = 1'b0;
    trap_i         = 1'b0;
    exc_cause_i    = '0;
    dbg_ack_i      = 1'b0;
    sleeping_i     = 1'b0;
    pc_if_i        = '0;
    pc_id_i        = '0;
    req_seen       = 1'b0;
    for (int i = 0; i < 32; i++) gpr_mem[i] = 32'hc0de0000 ^ (i * 32'h00010001);
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    e0 = total_errors();   // Reset state
    check_val("dbg_req_o", 32'h0, {31'b0, dbg_req_o});
    check_val("stall_o", 32'h0, {31'b0, stall_o});
    check_val("debug_halted_o", 32'h0, {31'b0, debug_halted_o});
    check_val("settings_o", 32'h0, {27'b0, settings_o});
    check_read("DBG_CTRL", win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0);
    check_read("DBG_CAUSE", win_addr(REGION_DBG_ALWAYS, REG_CAUSE), 32'h0000_001f);
    end_test("reset", e0);

    e0 = total_errors();   // Halt and resume by register and by pin
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0000);
    wait_halted(1'b1);
    check_val("stall_o", 32'h1, {31'b0, stall_o});
    check_read("DBG_CTRL", win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0000);
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0);
    wait_halted(1'b0);
    debug_halt_i = 1'b1;   // One-cycle pulse on the halt pin
    @(posedge clk);
    #1 debug_halt_i = 1'b0;
    wait_halted(1'b1);
    debug_resume_i = 1'b1;
    @(posedge clk);
    #1 debug_resume_i = 1'b0;
    wait_halted(1'b0);
    end_test("halt_resume", e0);

    e0 = total_errors();   // GPR access
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0000);
    wait_halted(1'b1);
    for (int k = 0; k < 4; k++) begin
      data = next_random(5);
      num  = data[4:0];
      data = next_random(32);
      write_reg(win_addr(REGION_GPR, num), data);
      check_val("gpr_mem", data, gpr_mem[num]);
      check_read("GPR", win_addr(REGION_GPR, num), data);
    end
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0);
    wait_halted(1'b0);
    write_reg(win_addr(REGION_GPR, 5'd3), next_random(32));   // Dropped while running
    check_read("GPR running", win_addr(REGION_GPR, 5'd3), 32'h0);
    end_test("gpr_access", e0);

    e0 = total_errors();   // Trap with single step
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h1);
    data  = next_random(6);
    cause = data[5:0];
    trap_i = 1'b1;
    exc_cause_i = cause;
    @(posedge clk);
    #1 trap_i = 1'b0;
    wait_halted(1'b1);
    check_read("DBG_CTRL", win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0001);
    check_read("DBG_CAUSE", win_addr(REGION_DBG_ALWAYS, REG_CAUSE),
               {cause[5], 26'b0, cause[4:0]});
    sleeping_i = 1'b1;   // Shows in DBG_HIT bit 16
    check_read("DBG_HIT", win_addr(REGION_DBG_ALWAYS, REG_HIT), 32'h0001_0001);
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_HIT), 32'h1);
    check_read("DBG_HIT", win_addr(REGION_DBG_ALWAYS, REG_HIT), 32'h0001_0000);
    sleeping_i = 1'b0;
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0);
    wait_halted(1'b0);
    end_test("trap_step", e0);

    e0 = total_errors();   // Interrupt enable mapping
    ie  = next_random(32);
    exp = '0;
    exp[11] = ie[11];
    exp[7]  = ie[7] | ie[5];   // Load and store bits share one setting
    exp[5]  = ie[7] | ie[5];
    exp[3]  = ie[3];
    exp[2]  = ie[2];
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_IE), ie);
    check_read("DBG_IE", win_addr(REGION_DBG_ALWAYS, REG_IE), exp);
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_IE), 32'h0000_0020);
    check_read("DBG_IE", win_addr(REGION_DBG_ALWAYS, REG_IE), 32'h0000_00a0);
    check_val("settings_o", 32'h4, {27'b0, settings_o});
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_IE), 32'h0);
    end_test("ie_map", e0);

    e0 = total_errors();   // PC view and redirect
    pc_if_i = next_random(32);
    pc_id_i = next_random(32);
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0000);
    wait_halted(1'b1);
    check_read("NPC", win_addr(REGION_DBG_HALTED, 5'd0), pc_if_i);
    check_read("PPC", win_addr(REGION_DBG_HALTED, 5'd1), pc_id_i);
    jumps = jump_cnt;
    data  = next_random(32);
    write_reg(win_addr(REGION_DBG_HALTED, 5'd0), data);
    check_val("jump_req_o pulses", jumps + 1, jump_cnt);
    check_val("jump_addr_o", data, last_jump);
    write_reg(win_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0);
    wait_halted(1'b0);
    end_test("pc_jump", e0);

    repeat (4) @(posedge clk);
    $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errors());
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
dbg_pkg.sv
dbg_access_decoder.sv
dbg_halt_ctrl.sv
dbg_read_resp.sv
debug_unit.sv
debug_unit_asserts.sv
tb_debug_unit.sv

// File: Makefile
TOP := tb_debug_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
